// File: hdl/rs_pkg.sv
// Sizes, functional unit classes and bus structs shared by the reservation station
// Modules import this inside their body and use rs_pkg:: names in their port lists
package rs_pkg;

	////////////////////
	// Sizes
	////////////////////

	localparam int rs_entries = 8;                       // Station slots
	localparam int prn_size   = 64;                      // Physical registers
	localparam int rob_size   = 32;                      // Reorder buffer entries
	localparam int xlen       = 64;                      // Operand width
	localparam int cdb_count  = 2;                       // Result buses
	localparam int fu_count   = 3;                       // Classes that can issue

	localparam int prn_tag_w  = $clog2(prn_size) + 1;    // 7 bit tag
	localparam int rob_idx_w  = $clog2(rob_size) + 1;    // 6 bit index
	localparam int op_type_w  = 6;                       // Operation code

	typedef logic [prn_tag_w-1:0] prn_tag_t;             // Producer tag
	typedef logic [rob_idx_w-1:0] rob_idx_t;             // ROB slot
	typedef logic [op_type_w-1:0] op_type_t;             // Opcode

	// Issue port p serves class p + 1, so multiplier, adder, memory
	typedef enum logic [1:0]
	{
		none           = 2'd0,                           // Idle slot
		use_multiplier,
		use_adder,
		use_memory
	} fu_class_t;

	////////////////////
	// Bus structs
	////////////////////

	// From rename, one per cycle
	typedef struct packed
	{
		op_type_t         op_type;
		fu_class_t        fu_class;                      // Unit that runs it
		prn_tag_t         dest_tag;                      // Result register
		rob_idx_t         rob_idx;
		logic [xlen-1:0]  opa;                           // Value, or tag in low bits
		logic             opa_valid;                     // High when opa is a value
		logic [xlen-1:0]  opb;
		logic             opb_valid;
	} rs_dispatch_t;

	// Result broadcast from a functional unit
	typedef struct packed
	{
		logic             valid;
		prn_tag_t         tag;                           // Register being written
		logic [xlen-1:0]  value;
	} cdb_t;

	// Operands and bookkeeping sent to a functional unit
	typedef struct packed
	{
		op_type_t         op_type;
		prn_tag_t         dest_tag;
		rob_idx_t         rob_idx;
		logic [xlen-1:0]  opa;
		logic [xlen-1:0]  opb;
	} rs_issue_t;

endpackage

// File: hdl/rs_entry.sv
// One reservation station slot
// Holds a dispatched instruction, snoops both CDBs for missing operands and
// raises ready once both operands are values and its unit is free
`timescale 1ns/1ps

module rs_entry
(
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 load,                          // Allocator picked this slot
	input  rs_pkg::rs_dispatch_t load_data,                     // Instruction from rename
	input  rs_pkg::cdb_t         cdb [rs_pkg::cdb_count],       // Result broadcasts
	input  logic                 mult_available,
	input  logic                 adder_available,
	input  logic                 memory_available,
	input  logic                 grant,                         // Issuing this cycle
	output logic                 in_use,
	output logic                 ready,
	output rs_pkg::fu_class_t    fu_class,
	output rs_pkg::rs_issue_t    payload
);

	import rs_pkg::*;

	op_type_t         op_type;                                  // Stored opcode
	prn_tag_t         dest_tag;
	rob_idx_t         rob_idx;
	logic [xlen-1:0]  opa;                                      // Value or waiting tag
	logic [xlen-1:0]  opb;
	logic             opa_valid;
	logic             opb_valid;
	logic             unit_ready;                               // Class unit free

	logic [xlen:0]    load_opa;                                 // {valid, value} at load
	logic [xlen:0]    load_opb;
	logic [xlen:0]    wait_opa;                                 // {valid, value} while waiting
	logic [xlen:0]    wait_opb;

	// Operand after a look at both buses
	// A later bus wins if both match, which a correct core never sends
	function automatic logic [xlen:0] wake
	(
		input logic            op_valid,
		input logic [xlen-1:0] op,
		input cdb_t            bus [cdb_count]
	);
		logic [xlen:0] result;
		result = {op_valid, op};                               // Keep as is by default
		for (int i = 0; i < cdb_count; i++)
		begin
			if (!op_valid && bus[i].valid && bus[i].tag == op[prn_tag_w-1:0])
				result = {1'b1, bus[i].value};                 // Tag hit, take the value
		end
		return result;
	endfunction

	////////////////////
	// Wakeup
	////////////////////

	always_comb
	begin
		load_opa = wake(load_data.opa_valid, load_data.opa, cdb);  // Bypass on load
		load_opb = wake(load_data.opb_valid, load_data.opb, cdb);
		wait_opa = wake(opa_valid, opa, cdb);
		wait_opb = wake(opb_valid, opb, cdb);
	end

	always_comb
	begin
		case (fu_class)
			use_multiplier: unit_ready = mult_available;
			use_adder:      unit_ready = adder_available;
			use_memory:     unit_ready = memory_available;
			default:        unit_ready = 1'b0;             // Idle slot never issues
		endcase
	end

	assign ready = in_use & opa_valid & opb_valid & unit_ready;

	assign payload = '{
		op_type:  op_type,
		dest_tag: dest_tag,
		rob_idx:  rob_idx,
		opa:      opa,
		opb:      opb
	};

	////////////////////
	// Slot state
	////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			in_use    <= 1'b0;
			opa_valid <= 1'b0;
			opb_valid <= 1'b0;
			fu_class  <= none;
		end
		else if (load)
		begin
			in_use    <= 1'b1;                                  // Slot taken
			opa_valid <= load_opa[xlen];
			opb_valid <= load_opb[xlen];
			fu_class  <= load_data.fu_class;
		end
		else if (in_use)
		begin
			opa_valid <= wait_opa[xlen];
			opb_valid <= wait_opb[xlen];
			if (grant)
				in_use <= 1'b0;                                 // Freed after issue
		end
	end

	always_ff @(posedge clock)
	begin
		if (load)
		begin
			op_type  <= load_data.op_type;
			dest_tag <= load_data.dest_tag;
			rob_idx  <= load_data.rob_idx;
			opa      <= load_opa[xlen-1:0];
			opb      <= load_opb[xlen-1:0];
		end
		else if (in_use)
		begin
			opa <= wait_opa[xlen-1:0];                          // Unchanged unless woken
			opb <= wait_opb[xlen-1:0];
		end
	end

endmodule

// File: hdl/rs_alloc.sv
// Slot allocator for the reservation station
// Points a dispatch at the lowest free slot and reports when none is left
// Purely combinational
`timescale 1ns/1ps

module rs_alloc
(
	input  logic                          dispatch_valid,   // Strobe from rename
	input  logic [rs_pkg::rs_entries-1:0] in_use,           // One bit per slot
	output logic [rs_pkg::rs_entries-1:0] load,             // One-hot, or zero
	output logic                          full
);

	import rs_pkg::*;

	logic found;                                            // Free slot already taken

	////////////////////
	// Lowest free slot
	////////////////////

	always_comb
	begin
		load  = '0;
		found = 1'b0;
		for (int i = 0; i < rs_entries; i++)
		begin
			if (!in_use[i] && !found)
			begin
				load[i] = dispatch_valid;                       // Only on a real dispatch
				found   = 1'b1;
			end
		end
	end

	// Issuing slots still count as busy
	assign full = &in_use;

	// When full no load bit is set and the dispatch is lost

endmodule

// File: hdl/rs_issue_select.sv
// Issue selector for the reservation station
// For each unit class, grants the lowest-index ready slot of that class and
// forwards its payload to the class issue port
// Port p serves class p + 1; ports with nothing to send read zero
`timescale 1ns/1ps

module rs_issue_select
(
	input  logic [rs_pkg::rs_entries-1:0] ready,                        // Per slot
	input  rs_pkg::fu_class_t             fu_class [rs_pkg::rs_entries], // Slot class
	input  rs_pkg::rs_issue_t             payload [rs_pkg::rs_entries],  // Slot contents
	output logic [rs_pkg::rs_entries-1:0] grant,                        // Slot frees
	output logic [rs_pkg::fu_count-1:0]   issue_valid,                  // Per port
	output rs_pkg::rs_issue_t             issue [rs_pkg::fu_count]
);

	import rs_pkg::*;

	////////////////////
	// Per class priority
	////////////////////

	always_comb
	begin
		grant       = '0;
		issue_valid = '0;
		issue       = '{default: '0};                          // Idle ports read zero
		for (int p = 0; p < fu_count; p++)
		begin
			for (int e = 0; e < rs_entries; e++)
			begin
				// First match in index order wins, port class skips none
				if (!issue_valid[p] && ready[e] && fu_class[e] == fu_class_t'(p + 1))
				begin
					grant[e]       = 1'b1;
					issue_valid[p] = 1'b1;
					issue[p]       = payload[e];
				end
			end
		end
	end

	// A slot has one class, so at most one port can grant it

endmodule

// File: hdl/reservation_station.sv
// Reservation station top level
// Rename dispatches one instruction per cycle into a free slot, slots wake up
// from two CDBs, and one ready slot per unit class issues each cycle
// Issue ports are 0 multiplier, 1 adder, 2 memory
`timescale 1ns/1ps

module reservation_station
(
	input  logic                          clock,
	input  logic                          reset,

	// Rename side
	input  logic                          dispatch_valid,    // Strobe, ignored when full
	input  rs_pkg::rs_dispatch_t          dispatch,
	output logic                          full,              // Level

	// Functional unit side
	input  rs_pkg::cdb_t                  cdb [rs_pkg::cdb_count],
	input  logic                          mult_available,    // Levels
	input  logic                          adder_available,
	input  logic                          memory_available,
	output logic [rs_pkg::fu_count-1:0]   issue_valid,       // Strobes, one per class
	output rs_pkg::rs_issue_t             issue [rs_pkg::fu_count]
);

	import rs_pkg::*;

	logic [rs_entries-1:0] in_use;                          // Slot busy
	logic [rs_entries-1:0] load;                            // One-hot allocation
	logic [rs_entries-1:0] ready;                           // Slot can issue now
	logic [rs_entries-1:0] grant;                           // Slot issues now
	fu_class_t             fu_class [rs_entries];
	rs_issue_t             payload [rs_entries];

	////////////////////
	// Allocation
	////////////////////

	rs_alloc alloc_i
	(
		.dispatch_valid (dispatch_valid),
		.in_use         (in_use),
		.load           (load),
		.full           (full)
	);

	////////////////////
	// Slots
	////////////////////

	for (genvar i = 0; i < rs_entries; i++)
	begin : g_entry
		rs_entry entry_i
		(
			.clock            (clock),
			.reset            (reset),
			.load             (load[i]),
			.load_data        (dispatch),                   // Same bus to every slot
			.cdb              (cdb),
			.mult_available   (mult_available),
			.adder_available  (adder_available),
			.memory_available (memory_available),
			.grant            (grant[i]),
			.in_use           (in_use[i]),
			.ready            (ready[i]),
			.fu_class         (fu_class[i]),
			.payload          (payload[i])
		);
	end

	////////////////////
	// Issue
	////////////////////

	// Combinational, so a slot issues in the cycle it becomes ready
	rs_issue_select issue_select_i
	(
		.ready       (ready),
		.fu_class    (fu_class),
		.payload     (payload),
		.grant       (grant),
		.issue_valid (issue_valid),
		.issue       (issue)
	);

endmodule

// File: tb/reservation_station_tb.sv
// Testbench for the reservation station
// Builds a table of per-cycle stimulus and expected outputs, then applies it
// one row per clock and checks full and all three issue ports each cycle
`timescale 1ns/1ps

module reservation_station_tb;

	import rs_pkg::*;

	localparam int reset_cycles = 8;
	localparam int mult_port    = 0;                        // Port order of the DUT
	localparam int adder_port   = 1;
	localparam int memory_port  = 2;

	typedef logic [$bits(rs_issue_t)-1:0] word_t;           // Widest checked value

	// One table row, inputs first, then what the DUT shows in that cycle
	typedef struct packed
	{
		logic                     dispatch_valid;
		rs_dispatch_t             dispatch;
		cdb_t                     cdb_a;
		cdb_t                     cdb_b;
		logic                     mult_available;
		logic                     adder_available;
		logic                     memory_available;
		logic                     full;                     // Expected
		logic [fu_count-1:0]      issue_valid;              // Expected per port
		rs_issue_t [fu_count-1:0] issue;                    // Zero on idle ports
	} step_t;

	logic                clock;
	logic                reset;
	logic                dispatch_valid;
	rs_dispatch_t        dispatch;
	logic                full;
	cdb_t                cdb [cdb_count];
	logic                mult_available;
	logic                adder_available;
	logic                memory_available;
	logic [fu_count-1:0] issue_valid;
	rs_issue_t           issue [fu_count];

	step_t steps [$];                                       // Stimulus table
	string step_names [$];
	step_t cur;                                             // Row being built
	string cur_name;
	int    cycles;
	int    cycle_limit = 1000;                              // Replaced once table is known

	reservation_station reservation_station_i
	(
		.clock            (clock),
		.reset            (reset),
		.dispatch_valid   (dispatch_valid),
		.dispatch         (dispatch),
		.full             (full),
		.cdb              (cdb),
		.mult_available   (mult_available),
		.adder_available  (adder_available),
		.memory_available (memory_available),
		.issue_valid      (issue_valid),
		.issue            (issue)
	);

	always #50 clock = ~clock;                              // 100 ns period

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			stop_with_failure("Timeout, the run went past its cycle limit");
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic report_mismatch(input string step, input string what,
		input word_t expected, input word_t actual);
		stop_with_failure($sformatf("Fail %s %s expected %0h actual %0h",
			step, what, expected, actual));
	endtask

	////////////////////
	// Table builders
	////////////////////

	function automatic cdb_t bus_of(input logic valid, input prn_tag_t tag,
		input logic [xlen-1:0] value);
		return '{valid: valid, tag: tag, value: value};
	endfunction

	task automatic begin_step(input string name);
		cur                  = '0;                          // No dispatch, buses idle
		cur.mult_available   = 1'b1;
		cur.adder_available  = 1'b1;
		cur.memory_available = 1'b1;
		cur_name             = name;
	endtask

	task automatic end_step();
		steps.push_back(cur);
		step_names.push_back(cur_name);
	endtask

	task automatic send(input op_type_t op, input fu_class_t cls, input prn_tag_t dest,
		input rob_idx_t rob, input logic [xlen-1:0] opa, input logic opa_valid,
		input logic [xlen-1:0] opb, input logic opb_valid);
		cur.dispatch_valid = 1'b1;
		cur.dispatch = '{op_type: op, fu_class: cls, dest_tag: dest, rob_idx: rob,
			opa: opa, opa_valid: opa_valid, opb: opb, opb_valid: opb_valid};
	endtask

	task automatic expect_issue(input int port, input op_type_t op, input prn_tag_t dest,
		input rob_idx_t rob, input logic [xlen-1:0] opa, input logic [xlen-1:0] opb);
		cur.issue_valid[port] = 1'b1;
		cur.issue[port] = '{op_type: op, dest_tag: dest, rob_idx: rob, opa: opa, opb: opb};
	endtask

	task automatic build_table();
		begin_step("reset_idle"); end_step();
		begin_step("add_dispatch");                         // Both values, lands in slot 0
		send(6'h01, use_adder, 7'h05, 6'h01, 64'h10, 1'b1, 64'h20, 1'b1); end_step();
		begin_step("add_issue");
		expect_issue(adder_port, 6'h01, 7'h05, 6'h01, 64'h10, 64'h20); end_step();
		begin_step("add_once"); end_step();                 // Slot freed, no repeat
		begin_step("mul_wait_dispatch");                    // opa waits on tag 11
		send(6'h02, use_multiplier, 7'h06, 6'h02, 64'h11, 1'b0, 64'h30, 1'b1); end_step();
		begin_step("cdb_miss");
		cur.cdb_a = bus_of(1'b1, 7'h12, 64'hdead);          // Wrong tag
		cur.cdb_b = bus_of(1'b0, 7'h11, 64'hbeef);          // Right tag, not valid
		end_step();
		begin_step("cdb_b_wake");
		cur.cdb_b = bus_of(1'b1, 7'h11, 64'haaaa); end_step();
		begin_step("mul_issue");
		expect_issue(mult_port, 6'h02, 7'h06, 6'h02, 64'haaaa, 64'h30); end_step();
		begin_step("bypass_dispatch");                      // opa caught at load
		send(6'h03, use_memory, 7'h07, 6'h03, 64'h21, 1'b0, 64'h22, 1'b0);
		cur.cdb_a = bus_of(1'b1, 7'h21, 64'h1111); end_step();
		begin_step("cdb_a_wake");
		cur.cdb_a = bus_of(1'b1, 7'h22, 64'h2222); end_step();
		begin_step("mem_issue");
		expect_issue(memory_port, 6'h03, 7'h07, 6'h03, 64'h1111, 64'h2222); end_step();
		// Adders held back, multiplier free
		begin_step("adds_held_0"); cur.adder_available = 1'b0;
		send(6'h04, use_adder, 7'h08, 6'h04, 64'h1, 1'b1, 64'h2, 1'b1); end_step();
		begin_step("adds_held_1"); cur.adder_available = 1'b0;
		send(6'h05, use_adder, 7'h09, 6'h05, 64'h3, 1'b1, 64'h4, 1'b1); end_step();
		begin_step("adds_held_2"); cur.adder_available = 1'b0;
		send(6'h06, use_multiplier, 7'h0a, 6'h06, 64'h5, 1'b1, 64'h6, 1'b1); end_step();
		begin_step("adder_rise");                           // Slot 0 adder and slot 2 mult
		expect_issue(adder_port, 6'h04, 7'h08, 6'h04, 64'h1, 64'h2);
		expect_issue(mult_port, 6'h06, 7'h0a, 6'h06, 64'h5, 64'h6); end_step();
		begin_step("adder_next");
		expect_issue(adder_port, 6'h05, 7'h09, 6'h05, 64'h3, 64'h4); end_step();
		begin_step("adder_drained"); end_step();
		// Fill all eight slots with memory ops that cannot issue
		for (int k = 0; k < rs_entries; k++)
		begin
			begin_step($sformatf("fill_%0d", k)); cur.memory_available = 1'b0;
			send(op_type_t'(16 + k), use_memory, prn_tag_t'(16 + k), rob_idx_t'(16 + k),
				64'(4096 + k), 1'b1, 64'(8192 + k), 1'b1);
			end_step();
		end
		begin_step("full_drop"); cur.memory_available = 1'b0; cur.full = 1'b1;
		send(6'h3f, use_memory, 7'h3f, 6'h3f, 64'h99, 1'b1, 64'h99, 1'b1); end_step();
		begin_step("full_release"); cur.full = 1'b1;        // Issuing slot still busy
		expect_issue(memory_port, 6'h10, 7'h10, 6'h10, 64'h1000, 64'h2000); end_step();
		begin_step("refill"); cur.memory_available = 1'b0;  // Takes freed slot 0
		send(6'h2a, use_memory, 7'h2a, 6'h2a, 64'h77, 1'b1, 64'h88, 1'b1); end_step();
		begin_step("refill_issue"); cur.full = 1'b1;        // Slot 0 goes first
		expect_issue(memory_port, 6'h2a, 7'h2a, 6'h2a, 64'h77, 64'h88); end_step();
		for (int k = 1; k < rs_entries; k++)
		begin
			begin_step($sformatf("drain_%0d", k));
			expect_issue(memory_port, op_type_t'(16 + k), prn_tag_t'(16 + k),
				rob_idx_t'(16 + k), 64'(4096 + k), 64'(8192 + k));
			end_step();
		end
		begin_step("all_drained"); end_step();              // Dropped op never shows
	endtask

	////////////////////
	// Drive and check
	////////////////////

	task automatic apply_step(input step_t s);
		dispatch_valid   = s.dispatch_valid;
		dispatch         = s.dispatch;
		cdb[0]           = s.cdb_a;
		cdb[1]           = s.cdb_b;
		mult_available   = s.mult_available;
		adder_available  = s.adder_available;
		memory_available = s.memory_available;
	endtask

	task automatic check_step(input step_t s, input string name);
		assert (full == s.full)
		else report_mismatch(name, "full", word_t'(s.full), word_t'(full));
		for (int p = 0; p < fu_count; p++)
		begin
			assert (issue_valid[p] == s.issue_valid[p])
			else report_mismatch(name, $sformatf("issue_valid[%0d]", p),
				word_t'(s.issue_valid[p]), word_t'(issue_valid[p]));
			assert (issue[p] == s.issue[p])
			else report_mismatch(name, $sformatf("issue[%0d]", p),
				word_t'(s.issue[p]), word_t'(issue[p]));
		end
	endtask

	initial
	begin
		clock  = 1'b0;
		reset  = 1'b1;
		cycles = 0;
		begin_step("init");
		apply_step(cur);                                    // All inputs idle
		build_table();
		cycle_limit = 2 * steps.size() + reset_cycles;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int i = 0; i < steps.size(); i++)
		begin
			@(negedge clock);
			apply_step(steps[i]);
			#25;                                            // Mid low phase, outputs settled
			check_step(steps[i], step_names[i]);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

// File: reservation_station.f
hdl/rs_pkg.sv
hdl/rs_entry.sv
hdl/rs_alloc.sv
hdl/rs_issue_select.sv
hdl/reservation_station.sv
tb/reservation_station_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the reservation station testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -j 0 \
	-f reservation_station.f \
	--top-module reservation_station_tb \
	-o reservation_station_sim

# The simulator exits nonzero on a fatal error; the log decides the result
./obj_dir/reservation_station_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
exit 0
